/* design/apbConsoleRegs.sv */
`timescale 1ns/100ps
`include "console_defs.svh"

module apbConsoleRegs import consolePkg::*; (
    input  logic        clk,
    input  logic        reset,
    input  logic [3:0]  paddr,
    input  logic        psel,
    input  logic        penable,
    input  logic        pwrite,
    input  logic [31:0] pwdata,
    output logic [31:0] prdata,
    output logic        pready,
    output logic        pslverr,
    output logic        byteValid,
    output charT        byteData,
    input  logic        byteReady,
    input  statusT      status,
    output rowT         rdRow,
    output colT         rdCol,
    input  charT        rdData
);

    logic live;        // high from the first cycle out of reset
    logic access;      // apb access phase
    logic waitDone;    // rddata read already spent its wait cycle

    assign access  = live && psel && penable;
    assign pslverr = 1'b0;

    always_ff @(posedge clk) begin
        if (reset) begin
            live <= 1'b0;
        end else begin
            live <= 1'b1;
        end
    end

    // bank read is registered, so rddata needs one extra access cycle
    always_ff @(posedge clk) begin
        if (reset) begin
            waitDone <= 1'b0;
        end else if (access && !pwrite && paddr == `REG_RDDATA) begin
            waitDone <= !waitDone;
        end else begin
            waitDone <= 1'b0;
        end
    end

    always_comb begin
        pready = 1'b0;
        if (access) begin
            if (pwrite && paddr == `REG_DATA) begin
                pready = byteReady;     // held off while the parser clears
            end else if (!pwrite && paddr == `REG_RDDATA) begin
                pready = waitDone;
            end else begin
                pready = 1'b1;
            end
        end
    end

    assign byteValid = access && pwrite && (paddr == `REG_DATA);
    assign byteData  = pwdata[7:0];

    // read address for the cell port
    always_ff @(posedge clk) begin
        if (reset) begin
            rdRow <= '0;
            rdCol <= '0;
        end else if (access && pwrite && paddr == `REG_RDADDR) begin
            rdRow <= pwdata[6:4];
            rdCol <= pwdata[3:0];
        end
    end

    always_comb begin
        case (paddr)
            `REG_STATUS: prdata = {24'h0, status};
            `REG_RDADDR: prdata = {25'h0, rdRow, rdCol};
            `REG_RDDATA: prdata = {24'h0, rdData};
            default:     prdata = 32'h0;    // DATA and holes read as zero
        endcase
    end

    // access phase only ever follows a setup cycle
    apbSetupFirst: assert property (@(posedge clk) disable iff (reset)
        $rose(penable) |-> $past(psel));

endmodule

/* design/consolePkg.sv */
package consolePkg;

    typedef logic [7:0] charT;
    typedef logic [2:0] rowT;
    typedef logic [3:0] colT;
    typedef logic [1:0] slotT;   // column position inside one bank
    typedef logic [1:0] laneT;   // bank index

    // parser states
    typedef enum logic [2:0] {
        psClear,    // sweeping rows with spaces
        psIdle,
        psEsc,      // got ESC
        psCsi,      // got ESC [
        psCsi2      // got ESC [ 2
    } parseStateT;

    // read back through the STATUS register, 8 bits
    typedef struct packed {
        logic busy;
        rowT  cursorRow;
        colT  cursorCol;
    } statusT;

endpackage

/* design/rowReader.sv */
`timescale 1ns/100ps
`include "console_defs.svh"

module rowReader import consolePkg::*; (
    input  logic       clk,
    input  rowT        topRow,
    input  rowT        rdRow,
    input  colT        rdCol,
    output charT       rdData,
    textBankIf.reader  lanes [`CON_LANES]
);

    rowT  physRow;
    slotT rdSlot;
    laneT rdLane;
    laneT laneQ;                    // matches the registered bank read
    charT bankData [`CON_LANES];

    // logical row 0 sits at topRow after scrolling
    assign physRow = rowT'((rdRow + topRow) % `CON_ROWS);
    assign rdSlot  = slotT'(rdCol / `CON_LANES);
    assign rdLane  = laneT'(rdCol % `CON_LANES);

    // every bank looks up the same row and slot
    for (genvar i = 0; i < `CON_LANES; i++) begin : gLane
        assign lanes[i].rdRow  = physRow;
        assign lanes[i].rdSlot = rdSlot;
        assign bankData[i]     = lanes[i].rdData;
    end

    always_ff @(posedge clk) begin
        laneQ <= rdLane;
    end

    assign rdData = bankData[laneQ];

endmodule

/* design/textBank.sv */
`timescale 1ns/100ps
`include "console_defs.svh"

module textBank import consolePkg::*; (
    input logic      clk,
    textBankIf.bank  bank
);

    // one lane's columns for every physical row
    charT mem [`CON_ROWS][`CON_SLOTS];

    always_ff @(posedge clk) begin
        if (bank.clr) begin
            for (int s = 0; s < `CON_SLOTS; s++) begin
                mem[bank.wrRow][s] <= 8'h20;
            end
        end else if (bank.we) begin
            mem[bank.wrRow][bank.wrSlot] <= bank.wrData;
        end
    end

    // registered read port
    always_ff @(posedge clk) begin
        bank.rdData <= mem[bank.rdRow][bank.rdSlot];
    end

    // the parser never writes a cell and clears a row in the same cycle
    noWriteDuringClear: assert property (@(posedge clk)
        !(bank.we === 1'b1 && bank.clr === 1'b1));

endmodule

/* design/textBankIf.sv */
`timescale 1ns/100ps

interface textBankIf import consolePkg::*; ();

    // write side, owned by the parser
    logic we;
    logic clr;      // fill the whole of wrRow with spaces
    rowT  wrRow;
    slotT wrSlot;
    charT wrData;

    // read side
    rowT  rdRow;
    slotT rdSlot;
    charT rdData;   // registered, one cycle behind rdRow and rdSlot

    modport writer (output we, clr, wrRow, wrSlot, wrData);
    modport reader (output rdRow, rdSlot, input rdData);
    modport bank (
        input  we, clr, wrRow, wrSlot, wrData, rdRow, rdSlot,
        output rdData
    );

endinterface

/* design/textConsole.sv */
`timescale 1ns/100ps
`include "console_defs.svh"

module textConsole import consolePkg::*; (
    input  logic        clk,
    input  logic        reset,
    input  logic [3:0]  paddr,
    input  logic        psel,
    input  logic        penable,
    input  logic        pwrite,
    input  logic [31:0] pwdata,
    output logic [31:0] prdata,
    output logic        pready,
    output logic        pslverr
);

    logic   byteValid;
    charT   byteData;
    logic   byteReady;
    statusT status;
    rowT    topRow;
    rowT    rdRow;
    colT    rdCol;
    charT   rdData;

    textBankIf bankBus [`CON_LANES] ();

    apbConsoleRegs regs0 (
        .clk,
        .reset,
        .paddr,
        .psel,
        .penable,
        .pwrite,
        .pwdata,
        .prdata,
        .pready,
        .pslverr,
        .byteValid,
        .byteData,
        .byteReady,
        .status,
        .rdRow,
        .rdCol,
        .rdData
    );

    vt100Parser parser0 (
        .clk,
        .reset,
        .byteValid,
        .byteData,
        .byteReady,
        .status,
        .topRow,
        .lanes(bankBus)
    );

    // column-interleaved storage, lane i holds columns i, i+4, ...
    for (genvar i = 0; i < `CON_LANES; i++) begin : gBank
        textBank bank0 (
            .clk,
            .bank(bankBus[i])
        );
    end

    rowReader reader0 (
        .clk,
        .topRow,
        .rdRow,
        .rdCol,
        .rdData,
        .lanes(bankBus)
    );

endmodule

/* design/vt100Parser.sv */
`timescale 1ns/100ps
`include "console_defs.svh"

module vt100Parser import consolePkg::*; (
    input  logic       clk,
    input  logic       reset,
    input  logic       byteValid,
    input  charT       byteData,
    output logic       byteReady,
    output statusT     status,
    output rowT        topRow,
    textBankIf.writer  lanes [`CON_LANES]
);

    localparam charT chBs  = 8'h08;
    localparam charT chLf  = 8'h0A;
    localparam charT chCr  = 8'h0D;
    localparam charT chEsc = 8'h1B;

    parseStateT state;
    rowT  cursorRow;
    colT  cursorCol;
    rowT  clrRow;           // sweep position in psClear
    logic scrollPending;    // wrap on bottom row, row clear follows next cycle

    logic accept;
    logic printable;
    logic onBottom;
    logic atLastCol;
    logic doWrite;
    logic lfScroll;
    logic clrEn;
    rowT  clrSel;
    rowT  nextTop;
    rowT  writeRow;
    laneT writeLane;
    slotT writeSlot;

    assign byteReady = (state != psClear) && !scrollPending;
    assign accept    = byteValid && byteReady;
    assign printable = (byteData >= 8'h20) && (byteData <= 8'h7E);
    assign onBottom  = (cursorRow == rowT'(`CON_ROWS - 1));
    assign atLastCol = (cursorCol == colT'(`CON_COLS - 1));
    assign doWrite   = accept && (state == psIdle) && printable;
    assign lfScroll  = accept && (state == psIdle) && (byteData == chLf) && onBottom;

    assign nextTop   = rowT'((topRow + 1) % `CON_ROWS);
    assign writeRow  = rowT'((cursorRow + topRow) % `CON_ROWS);
    assign writeLane = laneT'(cursorCol % `CON_LANES);
    assign writeSlot = slotT'(cursorCol / `CON_LANES);

    // pick the row being blanked, at most one source per cycle
    always_comb begin
        clrEn  = 1'b1;
        clrSel = topRow;    // lf scroll: old top row becomes the new bottom
        if (state == psClear) begin
            clrSel = clrRow;
        end else if (scrollPending) begin
            clrSel = rowT'((topRow + `CON_ROWS - 1) % `CON_ROWS);
        end else if (!lfScroll) begin
            clrEn = 1'b0;
        end
    end

    for (genvar i = 0; i < `CON_LANES; i++) begin : gLane
        assign lanes[i].we     = doWrite && (writeLane == laneT'(i));
        assign lanes[i].clr    = clrEn;     // all banks blank their part of the row
        assign lanes[i].wrRow  = clrEn ? clrSel : writeRow;
        assign lanes[i].wrSlot = writeSlot;
        assign lanes[i].wrData = byteData;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state         <= psClear;
            clrRow        <= '0;
            cursorRow     <= '0;
            cursorCol     <= '0;
            topRow        <= '0;
            scrollPending <= 1'b0;
        end else begin
            scrollPending <= 1'b0;
            if (state == psClear) begin
                clrRow <= rowT'(clrRow + 1'b1);
                if (clrRow == rowT'(`CON_ROWS - 1)) begin
                    state <= psIdle;
                end
            end else if (accept) begin
                case (state)
                    psIdle: begin
                        if (printable) begin
                            if (atLastCol) begin
                                cursorCol <= '0;
                                if (onBottom) begin
                                    topRow        <= nextTop;
                                    scrollPending <= 1'b1;
                                end else begin
                                    cursorRow <= rowT'(cursorRow + 1'b1);
                                end
                            end else begin
                                cursorCol <= colT'(cursorCol + 1'b1);
                            end
                        end else begin
                            case (byteData)
                                chCr: cursorCol <= '0;
                                chBs: begin
                                    if (cursorCol != '0) begin
                                        cursorCol <= colT'(cursorCol - 1'b1);
                                    end
                                end
                                chLf: begin
                                    if (onBottom) begin
                                        topRow <= nextTop;  // row cleared this cycle
                                    end else begin
                                        cursorRow <= rowT'(cursorRow + 1'b1);
                                    end
                                end
                                chEsc: state <= psEsc;
                                default: ;                  // other controls ignored
                            endcase
                        end
                    end
                    psEsc: state <= (byteData == "[") ? psCsi : psIdle;
                    psCsi: begin
                        state <= psIdle;
                        if (byteData == "H") begin
                            cursorRow <= '0;
                            cursorCol <= '0;
                        end else if (byteData == "2") begin
                            state <= psCsi2;
                        end
                    end
                    psCsi2: begin
                        state <= psIdle;
                        if (byteData == "J") begin
                            // full clear, back to a fresh screen
                            cursorRow <= '0;
                            cursorCol <= '0;
                            topRow    <= '0;
                            clrRow    <= '0;
                            state     <= psClear;
                        end
                    end
                    default: state <= psIdle;
                endcase
            end
        end
    end

    assign status = '{busy: (state == psClear), cursorRow: cursorRow, cursorCol: cursorCol};

    cursorInRange: assert property (@(posedge clk) disable iff (reset)
        int'(cursorCol) < `CON_COLS);

    // a clear sweep keeps busy up for exactly one cycle per row
    clearLength: assert property (@(posedge clk) disable iff (reset)
        $rose(status.busy) |-> status.busy [* `CON_ROWS] ##1 !status.busy);

endmodule

/* include/console_defs.svh */
`ifndef CONSOLE_DEFS_SVH
`define CONSOLE_DEFS_SVH

// screen geometry in characters
`define CON_COLS    16
`define CON_ROWS    8

// text banks, each bank owns every CON_LANES-th column
`define CON_LANES   4
`define CON_SLOTS   (`CON_COLS / `CON_LANES)   // columns held per bank

// apb byte offsets
`define REG_DATA    4'h0    // byte stream into the parser
`define REG_STATUS  4'h4
`define REG_RDADDR  4'h8    // logical row in 6:4, column in 3:0
`define REG_RDDATA  4'hC

`endif

/* tb.f */
+incdir+include
design/consolePkg.sv
design/textBankIf.sv
design/apbConsoleRegs.sv
design/vt100Parser.sv
design/textBank.sv
design/rowReader.sv
design/textConsole.sv
verification/consoleTb.sv

/* verification/consoleTb.sv */
`timescale 1ns/100ps
`include "console_defs.svh"

module consoleTb import consolePkg::*; ();

    localparam int readyLimit = 32;    // access cycles before a transfer is given up
    localparam int busyLimit  = 20;    // status polls after reset

    logic        clk = 1'b0;
    logic        reset;
    logic [3:0]  paddr;
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [31:0] pwdata;
    logic [31:0] prdata;
    logic        pready;
    logic        pslverr;

    charT scr [`CON_ROWS][`CON_COLS];  // expected screen by logical row
    int   curRow;
    int   curCol;
    int   escState;                    // 0 idle, 1 ESC, 2 ESC [, 3 ESC [ 2
    int   charErrors;
    int   statusErrors;
    int   holdErrors;
    int   respErrors;
    bit   aborted;

    textConsole dut0 (
        .clk,
        .reset,
        .paddr,
        .psel,
        .penable,
        .pwrite,
        .pwdata,
        .prdata,
        .pready,
        .pslverr
    );

    always #4 clk = ~clk;

    // slave error response is never used by this slave
    task automatic checkSlvErr(input logic got, input logic [3:0] addr);
        if (got !== 1'b0) begin
            respErrors++;
            $display("[FAIL] %0t: pslverr %b at offset %h, expected 0", $time, got, addr);
        end
    endtask

    // one apb transfer that also counts the stalled access cycles
    task automatic apbXfer(input logic [3:0] addr, input logic wr, input logic [31:0] wdata,
                           output logic [31:0] rdata, output int stalls);
        @(posedge clk);
        paddr   <= addr;
        pwrite  <= wr;
        pwdata  <= wdata;
        psel    <= 1'b1;
        penable <= 1'b0;
        @(posedge clk);
        penable <= 1'b1;
        stalls = 0;
        @(negedge clk);                // pready and prdata settled mid-cycle
        while (!pready && !aborted) begin
            stalls++;
            if (stalls >= readyLimit) begin
                $display("timeout at %0t: pready stayed low at offset %h", $time, addr);
                aborted = 1'b1;
            end else begin
                @(negedge clk);
            end
        end
        rdata = prdata;
        checkSlvErr(pslverr, addr);
        @(posedge clk);
        psel    <= 1'b0;
        penable <= 1'b0;
    endtask

    task automatic checkChar(input charT got, input charT exp, input int row, input int col);
        if (got !== exp) begin
            charErrors++;
            $display("[FAIL] %0t: cell %0d,%0d read %h, expected %h", $time, row, col, got, exp);
        end
    endtask

    task automatic checkStatus(input statusT got, input statusT exp);
        if (got !== exp) begin
            statusErrors++;
            $display("[FAIL] %0t: status busy %b cursor %0d,%0d, expected busy %b cursor %0d,%0d",
                     $time, got.busy, got.cursorRow, got.cursorCol,
                     exp.busy, exp.cursorRow, exp.cursorCol);
        end
    endtask

    task automatic readCell(input int row, input int col, output charT ch);
        logic [31:0] d;
        int          n;
        apbXfer(`REG_RDADDR, 1'b1, {25'h0, 3'(row), 4'(col)}, d, n);
        apbXfer(`REG_RDDATA, 1'b0, 32'h0, d, n);
        ch = d[7:0];
    endtask

    task automatic readStatus(output statusT st);
        logic [31:0] d;
        int          n;
        apbXfer(`REG_STATUS, 1'b0, 32'h0, d, n);
        st = statusT'(d[7:0]);
    endtask

    function automatic void blankScreen();
        for (int r = 0; r < `CON_ROWS; r++) begin
            for (int c = 0; c < `CON_COLS; c++) begin
                scr[r][c] = 8'h20;
            end
        end
    endfunction

    // cursor down, or scroll the whole screen up from the bottom row
    function automatic void lineFeed();
        if (curRow == `CON_ROWS - 1) begin
            for (int r = 0; r < `CON_ROWS - 1; r++) begin
                for (int c = 0; c < `CON_COLS; c++) begin
                    scr[r][c] = scr[r + 1][c];
                end
            end
            for (int c = 0; c < `CON_COLS; c++) begin
                scr[`CON_ROWS - 1][c] = 8'h20;
            end
        end else begin
            curRow++;
        end
    endfunction

    function automatic void modelByte(input charT b);
        case (escState)
            0: begin
                if (b >= 8'h20 && b <= 8'h7E) begin
                    scr[curRow][curCol] = b;
                    if (curCol == `CON_COLS - 1) begin
                        curCol = 0;
                        lineFeed();
                    end else begin
                        curCol++;
                    end
                end else if (b == 8'h0D) begin
                    curCol = 0;
                end else if (b == 8'h08 && curCol > 0) begin
                    curCol--;      // nothing erased
                end else if (b == 8'h0A) begin
                    lineFeed();
                end else if (b == 8'h1B) begin
                    escState = 1;
                end
            end
            1: escState = (b == "[") ? 2 : 0;
            2: begin
                escState = (b == "2") ? 3 : 0;
                if (b == "H") begin
                    curRow = 0;
                    curCol = 0;
                end
            end
            default: begin
                escState = 0;
                if (b == "J") begin
                    blankScreen();
                    curRow = 0;
                    curCol = 0;
                end
            end
        endcase
    endfunction

    task automatic writeByte(input charT b, output int stalls);
        logic [31:0] d;
        apbXfer(`REG_DATA, 1'b1, {24'h0, b}, d, stalls);
        modelByte(b);
    endtask

    // every cell read back against the model across all four banks
    task automatic compareScreen();
        charT ch;
        for (int r = 0; r < `CON_ROWS; r++) begin
            for (int c = 0; c < `CON_COLS; c++) begin
                readCell(r, c, ch);
                checkChar(ch, scr[r][c], r, c);
            end
        end
    endtask

    initial begin
        string  op;
        string  line;
        int     fd;
        int     a;
        int     b;
        int     c;
        int     n;
        int     stalls;
        int     code;
        int     seedVal;
        charT   ch;
        statusT st;

        seedVal = $urandom(88);
        reset   <= 1'b1;
        paddr   <= '0;
        psel    <= 1'b0;
        penable <= 1'b0;
        pwrite  <= 1'b0;
        pwdata  <= '0;
        charErrors   = 0;
        statusErrors = 0;
        holdErrors   = 0;
        respErrors   = 0;
        aborted      = 1'b0;
        curRow       = 0;
        curCol       = 0;
        escState     = 0;
        blankScreen();
        repeat (8) @(posedge clk);
        reset <= 1'b0;

        // power-up clear sweep
        n = 0;
        readStatus(st);
        while (st.busy && !aborted) begin
            n++;
            if (n >= busyLimit) begin
                $display("timeout: busy never fell after reset");
                aborted = 1'b1;
            end else begin
                readStatus(st);
            end
        end

        fd = $fopen("verification/console_input.txt", "r");
        if (fd == 0) begin
            $display("could not open verification/console_input.txt");
            aborted = 1'b1;
        end
        while (!aborted && $fscanf(fd, " %s", op) == 1) begin
            case (op)
                "#": code = $fgets(line, fd);
                "W": begin
                    code = $fscanf(fd, " %h %d", a, n);
                    repeat (n) writeByte(charT'(a), stalls);
                end
                "B": begin
                    code = $fscanf(fd, " %h", a);
                    writeByte(charT'(a), stalls);
                    if (stalls == 0) begin
                        holdErrors++;
                        $display("[FAIL] %0t: DATA write %h was not held off", $time, a);
                    end
                end
                "R": begin
                    code = $fscanf(fd, " %d %d %h", a, b, c);
                    readCell(a, b, ch);
                    checkChar(ch, charT'(c), a, b);
                end
                "S": begin
                    code = $fscanf(fd, " %d %d %d", a, b, c);
                    readStatus(st);
                    checkStatus(st, statusT'({a[0], b[2:0], c[3:0]}));
                end
                "P": begin
                    code = $fscanf(fd, " %d", n);
                    repeat (n) writeByte(charT'(8'h20 + $urandom % 95), stalls);
                end
                "C": compareScreen();
                default: begin
                    $display("unknown op %s in the data file", op);
                    aborted = 1'b1;
                end
            endcase
        end
        if (fd != 0) begin
            $fclose(fd);
        end

        $display("errors: cells %0d, status %0d, back-pressure %0d, slverr %0d, aborted %0d",
                 charErrors, statusErrors, holdErrors, respErrors, aborted);
        if (charErrors + statusErrors + holdErrors + respErrors == 0 && !aborted) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

/* verification/console_input.txt */
# W byte count: write byte (hex) to DATA count times | B byte: DATA write that must stall
# R row col char(hex) | S busy row col | P count: random printables | C: all cells vs model
C
S 0 0 0
W 41 1
W 42 1
R 0 0 41
R 0 1 42
S 0 0 2
P 16
S 0 1 2
C
W 0D 1
W 08 1
S 0 1 0
W 0A 1
W 5A 1
W 08 1
S 0 2 0
R 2 0 5A
R 0 0 41
W 1B 1
W 5B 1
W 48 1
S 0 0 0
R 2 0 5A
W 0A 9
W 54 1
S 0 7 1
R 0 0 5A
R 7 0 54
R 7 1 20
C
W 1B 1
W 5B 1
W 32 1
W 4A 1
S 1 0 0
B 41
S 0 0 1
R 0 0 41
R 0 1 20
C
P 40
C
P 120
C
